//--- flist.f
design/ctrl_bus_pkg.sv
design/setting_map_pkg.sv
design/wb_slave_decode.sv
design/misc_regs.sv
design/settings_bus_16le.sv
design/setting_reg.sv
design/vita_time_64.sv
design/readback_mux_16le.sv
design/ctrl_core.sv
tests/ctrl_core_props.sv
tests/tb_ctrl_core.sv

//--- Bender.yml
package:
  name: ctrl_core

sources:
  # packages first, then leaf modules, then the top level
  - design/ctrl_bus_pkg.sv
  - design/setting_map_pkg.sv
  - design/wb_slave_decode.sv
  - design/misc_regs.sv
  - design/settings_bus_16le.sv
  - design/setting_reg.sv
  - design/vita_time_64.sv
  - design/readback_mux_16le.sv
  - design/ctrl_core.sv

  - target: test
    files:
      - tests/ctrl_core_props.sv
      - tests/tb_ctrl_core.sv

//--- tests/tb_ctrl_core.sv
// directed testbench for the control core, wishbone accesses, settings writes and vita time
`timescale 1ns/100ps
`default_nettype none

module tb_ctrl_core;
   import ctrl_bus_pkg::*;
   import setting_map_pkg::*;

   localparam real         CLK_PERIOD  = 4.0;
   localparam int          N_TESTS     = 5;
   localparam int          TEST_CYCLES = 2000;  // watchdog budget per test
   localparam int unsigned SEED        = 32'h62d6_f742;

   logic     wb_clk = 1'b0;
   logic     wb_rst;
   wb_addr_t wb_adr;
   wb_data_t wb_dat_w, wb_dat_r;
   logic     wb_we, wb_cyc, wb_stb, wb_ack;
   logic     pps;
   logic     cgen_status, cgen_ld, cgen_refmon;
   logic     cgen_sync_b, cgen_ref_sel;
   int       err_count   = 0;
   int       check_count = 0;

   always #(CLK_PERIOD/2) wb_clk = ~wb_clk;

   ctrl_core i_dut
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .pps_i(pps),
      .cgen_st_status_i(cgen_status), .cgen_st_ld_i(cgen_ld), .cgen_st_refmon_i(cgen_refmon),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   //////////////////////////////////////////////////
   // address map helpers

   function automatic wb_addr_t misc_addr(input logic [6:0] offset);
      return {SLV_MISC, offset};
   endfunction

   function automatic wb_addr_t rb_addr(input logic [3:0] word, input logic hi);
      return {SLV_READBACK, 1'b0, word, hi, 1'b0};
   endfunction

   function automatic wb_addr_t setting_addr(input set_addr_t reg_addr, input logic hi);
      return {1'b1, reg_addr, hi, 1'b0};  // upper half of the map
   endfunction

   //////////////////////////////////////////////////
   // bus tasks

   // called on a rising edge, returns one idle cycle after the ack
   task automatic wb_access(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                            output wb_data_t rdat);
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      do
         @(posedge wb_clk);
      while (!wb_ack);
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(posedge wb_clk);
   endtask

   task automatic wb_write16(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t ignored;
      wb_access(adr, 1'b1, dat, ignored);
   endtask

   task automatic wb_read16(input wb_addr_t adr, output wb_data_t dat);
      wb_access(adr, 1'b0, '0, dat);
   endtask

   task automatic write_setting(input set_addr_t reg_addr, input set_data_t dat);
      wb_write16(setting_addr(reg_addr, 1'b0), dat[15:0]);
      wb_write16(setting_addr(reg_addr, 1'b1), dat[31:16]);  // this one fires the strobe
   endtask

   task automatic read_word(input logic [3:0] word, output word_t dat);
      wb_data_t lo, hi;
      wb_read16(rb_addr(word, 1'b0), lo);
      wb_read16(rb_addr(word, 1'b1), hi);
      dat = {hi, lo};
   endtask

   // low word first, its low half latches the word
   task automatic read_time64(input logic [3:0] hi_word, input logic [3:0] lo_word,
                              output logic [63:0] t);
      word_t lo, hi;
      read_word(lo_word, lo);
      read_word(hi_word, hi);
      t = {hi, lo};
   endtask

   //////////////////////////////////////////////////
   // compare tasks

   task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_range(input logic [63:0] got, input logic [63:0] lo,
                              input logic [63:0] hi, input string what);
      check_count++;
      if ($isunknown(got) || got < lo || got > hi)
      begin
         err_count++;
         $display("Fail %0t: %s, got %h expected %h..%h", $time, what, got, lo, hi);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-20s %s", name, (err_count == errs_before) ? "ok" : "had errors");
   endtask

   //////////////////////////////////////////////////
   // tests

   task automatic test_cgen_ctrl;
      int         errs;
      wb_data_t   rd;
      logic [1:0] val;
      errs = err_count;
      val  = 2'($urandom % 3);  // never the reset value
      wb_read16(misc_addr(MISC_CGEN_CTRL), rd);
      check_data(rd, 16'h0003, "cgen ctrl after reset");
      check_bit(cgen_sync_b, 1'b1, "sync_b after reset");
      check_bit(cgen_ref_sel, 1'b1, "ref_sel after reset");
      wb_write16(misc_addr(MISC_CGEN_CTRL), {14'd0, val});
      wb_read16(misc_addr(MISC_CGEN_CTRL), rd);
      check_data(rd, {14'd0, val}, "cgen ctrl readback");
      check_bit(cgen_sync_b, val[1], "sync_b follows ctrl bit 1");
      check_bit(cgen_ref_sel, val[0], "ref_sel follows ctrl bit 0");
      report_test("cgen ctrl", errs);
   endtask

   task automatic test_scratch_status;
      int         errs;
      wb_data_t   wr, rd;
      logic [2:0] st;
      errs = err_count;
      repeat (4)
      begin
         wr = 16'($urandom);
         wb_write16(misc_addr(MISC_TEST), wr);
         wb_read16(misc_addr(MISC_TEST), rd);
         check_data(rd, wr, "scratch readback");
      end
      st = 3'($urandom);
      cgen_status <= st[2];
      cgen_ld     <= st[1];
      cgen_refmon <= st[0];
      @(posedge wb_clk);
      wb_read16(misc_addr(MISC_CGEN_ST), rd);
      check_data(rd, {13'd0, st}, "cgen status bits");
      wb_read16(misc_addr(7'd12), rd);
      check_data(rd, 16'hBEEF, "unused misc offset");
      report_test("scratch and status", errs);
   endtask

   task automatic test_settings_readback;
      int        errs;
      set_data_t d;
      word_t     w;
      errs = err_count;
      d    = $urandom;
      write_setting(SR_REG_TEST32, d);
      read_word(RB_TEST32, w);
      check_word(w, d, "test32 setting readback");
      read_word(RB_COMPAT, w);
      check_word(w, 32'h000A_0000, "compat number");
      read_word(4'd5, w);
      check_word(w, 32'h0, "unused readback word");
      report_test("settings readback", errs);
   endtask

   task automatic test_time_load_now;
      int          errs;
      logic [63:0] v, t1, t2;
      errs = err_count;
      // bit 31 clear keeps the low word from wrapping between the two word reads
      v = {$urandom, $urandom} & 64'h3fff_ffff_7fff_ffff;
      write_setting(SR_TIME64, v[63:32]);
      write_setting(set_addr_t'(SR_TIME64 + 1), v[31:0]);
      write_setting(set_addr_t'(SR_TIME64 + 2), 32'd1);  // load now
      read_time64(RB_TIME_HI, RB_TIME_LO, t1);
      check_range(t1, v, v + 200, "time after immediate load");
      read_time64(RB_TIME_HI, RB_TIME_LO, t2);
      check_range(t2, t1 + 1, t1 + 200, "time keeps counting");
      report_test("time load now", errs);
   endtask

   task automatic test_time_load_pps;
      int          errs;
      logic [63:0] v, t0, t1, t2, p;
      errs = err_count;
      v = ({$urandom, $urandom} & 64'h3fff_ffff_7fff_ffff) | 64'h4000_0000_0000_0000;
      write_setting(SR_TIME64, v[63:32]);
      write_setting(set_addr_t'(SR_TIME64 + 1), v[31:0]);
      write_setting(set_addr_t'(SR_TIME64 + 2), 32'd0);  // arm for next pps
      read_time64(RB_TIME_HI, RB_TIME_LO, t0);
      check_range(t0, 64'd0, v - 1, "time before pps stays below armed value");
      pps <= 1'b1;
      repeat (6) @(posedge wb_clk);  // sync plus edge detect is at most four cycles
      pps <= 1'b0;
      read_time64(RB_TIME_HI, RB_TIME_LO, t1);
      check_range(t1, v, v + 200, "time after pps load");
      read_time64(RB_PPS_HI, RB_PPS_LO, p);
      read_time64(RB_TIME_HI, RB_TIME_LO, t2);
      check_range(p, v, t2, "pps time at most current time");
      report_test("time load at pps", errs);
   endtask

   //////////////////////////////////////////////////
   // main sequence and watchdog

   initial
   begin
      int unsigned seed_state;
      seed_state  = $urandom(SEED);
      wb_rst      = 1'b1;
      wb_adr      = '0;
      wb_dat_w    = '0;
      wb_we       = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      pps         = 1'b0;
      cgen_status = 1'b0;
      cgen_ld     = 1'b0;
      cgen_refmon = 1'b0;
      @(posedge wb_clk);
      // readback request held over reset, no ack may come back
      wb_adr <= rb_addr(RB_COMPAT, 1'b0);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      repeat (15) @(posedge wb_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_rst <= 1'b0;
      @(posedge wb_clk);

      test_cgen_ctrl();
      test_scratch_status();
      test_settings_readback();
      test_time_load_now();
      test_time_load_pps();

      $display("%0d tests, %0d checks, %0d errors", N_TESTS, check_count, err_count);
      if (err_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("timeout: bus access never acknowledged");
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/ctrl_core_props.sv
// bus and settings strobe timing checks for the control core, bound into the top level
`timescale 1ns/100ps
`default_nettype none

module ctrl_core_props
  (
   input logic wb_clk,
   input logic wb_rst,
   input logic wb_cyc_i,
   input logic wb_stb_i,
   input logic wb_ack_i,
   input logic set_stb_i,
   input logic set_ack_i
  );

   // an ack only answers a live cycle
   a_ack_in_cycle : assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
      else $error("wishbone ack without cyc and stb");

   a_set_stb_with_ack : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_i |-> (set_ack_i && wb_ack_i))  // strobe and ack share the cycle
      else $error("settings strobe without settings ack");

   a_no_ack_in_reset : assert property (@(posedge wb_clk)
      wb_rst |-> !wb_ack_i)
      else $error("wishbone ack during reset");

endmodule

bind ctrl_core ctrl_core_props i_props
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
   .wb_ack_i(wb_ack_o), .set_stb_i(set_stb), .set_ack_i(set_bus_ack));

`default_nettype wire

//--- design/ctrl_core.sv
// control core top, wishbone decode, misc registers, settings bus, readback and vita time
`timescale 1ns/100ps
`default_nettype none

module ctrl_core
  (
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  ctrl_bus_pkg::wb_addr_t wb_adr_i,
   input  ctrl_bus_pkg::wb_data_t wb_dat_i,
   input  logic                   wb_we_i,
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   output ctrl_bus_pkg::wb_data_t wb_dat_o,
   output logic                   wb_ack_o,
   input  logic                   pps_i,
   input  logic                   cgen_st_status_i,
   input  logic                   cgen_st_ld_i,
   input  logic                   cgen_st_refmon_i,
   output logic                   cgen_sync_b_o,
   output logic                   cgen_ref_sel_o
  );
   import ctrl_bus_pkg::*;
   import setting_map_pkg::*;

   wb_data_t    misc_dat, rb_dat;
   logic        misc_stb, misc_ack, rb_stb, rb_ack, set_bus_stb, set_bus_ack;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   word_t       reg_test32;
   logic [63:0] vita_time, vita_time_pps;

   //////////////////////////////////////////////////
   // wishbone intercon, single master

   wb_slave_decode i_decode
     (.wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .misc_stb_o(misc_stb), .misc_dat_i(misc_dat), .misc_ack_i(misc_ack),
      .rb_stb_o(rb_stb), .rb_dat_i(rb_dat), .rb_ack_i(rb_ack),
      .set_bus_stb_o(set_bus_stb), .set_bus_ack_i(set_bus_ack));

   // slave 0
   misc_regs i_misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(misc_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   //////////////////////////////////////////////////
   // settings bus, slave 8 and up

   settings_bus_16le i_set_bus
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(set_bus_stb), .we_i(wb_we_i),
      .adr_i(wb_adr_i), .dat_i(wb_dat_i), .ack_o(set_bus_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   setting_reg #(.ADDR(SR_REG_TEST32), .payload_t(word_t)) i_sr_test32
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .out_o(reg_test32), .changed_o());

   vita_time_64 i_vita_time
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   //////////////////////////////////////////////////
   // readback, slave 7

   readback_mux_16le i_readback
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .stb_i(rb_stb), .adr_i(wb_adr_i),
      .dat_o(rb_dat), .ack_o(rb_ack),
      .time_i(vita_time), .time_pps_i(vita_time_pps), .test32_i(reg_test32));

endmodule

`default_nettype wire

//--- design/readback_mux_16le.sv
// readback mux, 32-bit status words read as two 16-bit halves with the high half latched
`timescale 1ns/100ps
`default_nettype none

module readback_mux_16le
  (
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   stb_i,
   input  ctrl_bus_pkg::wb_addr_t adr_i,
   output ctrl_bus_pkg::wb_data_t dat_o,
   output logic                   ack_o,
   input  logic [63:0]            time_i,
   input  logic [63:0]            time_pps_i,
   input  setting_map_pkg::word_t test32_i
  );
   import ctrl_bus_pkg::*;
   import setting_map_pkg::*;

   word_t    sel_word;
   wb_data_t hi_latch;  // keeps both halves of one word coherent

   always_comb
   begin
      case (adr_i[5:2])
         RB_TIME_HI: sel_word = time_i[63:32];
         RB_TIME_LO: sel_word = time_i[31:0];
         RB_PPS_HI:  sel_word = time_pps_i[63:32];
         RB_PPS_LO:  sel_word = time_pps_i[31:0];
         RB_TEST32:  sel_word = test32_i;
         RB_COMPAT:  sel_word = COMPAT_NUM;
         default:    sel_word = '0;  // unused words
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   always_ff @(posedge wb_clk)
   begin
      if (stb_i && !ack_o)
      begin
         if (!adr_i[1])
         begin
            dat_o    <= sel_word[15:0];
            hi_latch <= sel_word[31:16];
         end
         else
            dat_o <= hi_latch;
      end
   end

endmodule

`default_nettype wire

//--- design/vita_time_64.sv
// vita time counter, 64-bit free running time with pps latch and immediate or pps loads
`timescale 1ns/100ps
`default_nettype none

module vita_time_64
  (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic                       set_stb_i,
   input  setting_map_pkg::set_addr_t set_addr_i,
   input  setting_map_pkg::set_data_t set_data_i,
   input  logic                       pps_i,
   output logic [63:0]                vita_time_o,
   output logic [63:0]                vita_time_pps_o
  );
   import setting_map_pkg::*;

   set_data_t  time_hi, time_lo;
   time_ctrl_t load_now;
   logic       ctrl_wr;
   logic [1:0] pps_sync;
   logic       pps_del, pps_edge;
   logic       armed;  // load waits for the next pps edge

   //////////////////////////////////////////////////
   // time-set registers

   setting_reg #(.ADDR(SR_TIME64), .payload_t(set_data_t)) sr_time_hi
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(time_hi), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(SR_TIME64 + 1)), .payload_t(set_data_t)) sr_time_lo
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(time_lo), .changed_o());

   // writing ctrl is what triggers the load
   setting_reg #(.ADDR(set_addr_t'(SR_TIME64 + 2)), .payload_t(time_ctrl_t)) sr_time_ctrl
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
      .set_data_i(set_data_i), .out_o(load_now), .changed_o(ctrl_wr));

   //////////////////////////////////////////////////
   // pps sync, counter and latch

   assign pps_edge = pps_sync[1] & ~pps_del;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync        <= '0;
         pps_del         <= 1'b0;
         armed           <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_del  <= pps_sync[1];

         if (ctrl_wr)
            armed <= ~load_now;
         else if (pps_edge)
            armed <= 1'b0;

         if ((ctrl_wr && load_now) || (pps_edge && armed))
            vita_time_o <= {time_hi, time_lo}; // load wins over the count
         else
            vita_time_o <= vita_time_o + 64'd1;

         if (pps_edge)
            vita_time_pps_o <= armed ? {time_hi, time_lo} : vita_time_o;
      end
   end

endmodule

`default_nettype wire

//--- design/setting_reg.sv
// settings register, captures its payload when the settings strobe hits its address
`timescale 1ns/100ps
`default_nettype none

module setting_reg
  #(
   parameter setting_map_pkg::set_addr_t ADDR = '0,
   parameter type payload_t = setting_map_pkg::set_data_t
  )
  (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic                       set_stb_i,
   input  setting_map_pkg::set_addr_t set_addr_i,
   input  setting_map_pkg::set_data_t set_data_i,
   output payload_t                   out_o,
   output logic                       changed_o
  );

   logic hit;

   assign hit = set_stb_i & (set_addr_i == ADDR);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         out_o     <= '0;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit; // same edge as the new value
         if (hit)
            out_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
      end
   end

endmodule

`default_nettype wire

//--- design/settings_bus_16le.sv
// settings bus bridge, pairs of 16-bit wishbone writes become one 32-bit settings strobe
`timescale 1ns/100ps
`default_nettype none

module settings_bus_16le
  (
   input  logic                       wb_clk,
   input  logic                       wb_rst,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  ctrl_bus_pkg::wb_addr_t     adr_i,
   input  ctrl_bus_pkg::wb_data_t     dat_i,
   output logic                       ack_o,
   output logic                       set_stb_o,
   output setting_map_pkg::set_addr_t set_addr_o,
   output setting_map_pkg::set_data_t set_data_o
  );
   import ctrl_bus_pkg::*;

   wb_data_t low_hold;  // low half waits here for its high half
   logic     wr_first;  // first cycle of a write, before ack

   assign wr_first = stb_i & we_i & ~ack_o;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end
      else
      begin
         ack_o     <= stb_i & ~ack_o;    // one ack per access, reads included
         set_stb_o <= wr_first & adr_i[1];
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_first && !adr_i[1])
         low_hold <= dat_i;
      if (wr_first && adr_i[1])
      begin
         set_addr_o <= adr_i[9:2];     // 32-bit register index
         set_data_o <= {dat_i, low_hold};
      end
   end

endmodule

`default_nettype wire

//--- design/misc_regs.sv
// misc register slave, clock generator control, scratch word and clock generator status
`timescale 1ns/100ps
`default_nettype none

module misc_regs
  (
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  ctrl_bus_pkg::wb_addr_t adr_i,
   input  ctrl_bus_pkg::wb_data_t dat_i,
   output ctrl_bus_pkg::wb_data_t dat_o,
   output logic                   ack_o,
   input  logic                   cgen_st_status_i,
   input  logic                   cgen_st_ld_i,
   input  logic                   cgen_st_refmon_i,
   output logic                   cgen_sync_b_o,
   output logic                   cgen_ref_sel_o
  );
   import ctrl_bus_pkg::*;

   logic [1:0] cgen_ctrl;
   wb_data_t   reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         cgen_ctrl <= CGEN_CTRL_RESET;
         reg_test  <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i[6:0])
            MISC_CGEN_CTRL: cgen_ctrl <= dat_i[1:0];
            MISC_TEST:      reg_test  <= dat_i;
            default:        ;
         endcase
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = cgen_ctrl;

   always_comb
   begin
      case (adr_i[6:0])
         MISC_CGEN_CTRL: dat_o = {{(WB_DW-2){1'b0}}, cgen_ctrl};
         MISC_CGEN_ST:   dat_o = {{(WB_DW-3){1'b0}}, cgen_st_status_i, cgen_st_ld_i,
                                  cgen_st_refmon_i};
         MISC_TEST:      dat_o = reg_test;
         default:        dat_o = MISC_DEFAULT_RD;
      endcase
   end

   assign ack_o = stb_i; // zero wait state

endmodule

`default_nettype wire

//--- design/wb_slave_decode.sv
// wishbone slave decoder, splits the master strobe over three slaves and muxes data and ack
`timescale 1ns/100ps
`default_nettype none

module wb_slave_decode
  (
   input  ctrl_bus_pkg::wb_addr_t wb_adr_i,
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   output ctrl_bus_pkg::wb_data_t wb_dat_o,
   output logic                   wb_ack_o,
   output logic                   misc_stb_o,
   input  ctrl_bus_pkg::wb_data_t misc_dat_i,
   input  logic                   misc_ack_i,
   output logic                   rb_stb_o,
   input  ctrl_bus_pkg::wb_data_t rb_dat_i,
   input  logic                   rb_ack_i,
   output logic                   set_bus_stb_o,
   input  logic                   set_bus_ack_i
  );
   import ctrl_bus_pkg::*;

   logic [DECODE_W-1:0] slv;
   logic                misc_sel, rb_sel, set_sel;
   logic                req;

   assign slv      = wb_adr_i[WB_AW-1 -: DECODE_W];
   assign req      = wb_cyc_i & wb_stb_i;
   assign misc_sel = (slv == SLV_MISC);
   assign rb_sel   = (slv == SLV_READBACK);
   assign set_sel  = (slv[DECODE_W-1] == SLV_SETTINGS[DECODE_W-1]); // wide match

   assign misc_stb_o    = req & misc_sel;
   assign rb_stb_o      = req & rb_sel;
   assign set_bus_stb_o = req & set_sel;

   // undecoded slaves never ack, the master just waits
   assign wb_ack_o = (misc_sel & misc_ack_i) | (rb_sel & rb_ack_i) | (set_sel & set_bus_ack_i);

   always_comb
   begin
      if (misc_sel)
         wb_dat_o = misc_dat_i;
      else if (rb_sel)
         wb_dat_o = rb_dat_i;
      else
         wb_dat_o = '0; // settings bus is write only
   end

endmodule

`default_nettype wire

//--- design/setting_map_pkg.sv
// settings map package with settings addresses, readback word indices and payload types
`default_nettype none

package setting_map_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [31:0] word_t;      // one readback word
   typedef logic        time_ctrl_t; // 1 loads now, 0 waits for the next pps

   // settings bus register map
   localparam set_addr_t SR_TIME64     = 8'd42; // hi +0, lo +1, ctrl +2
   localparam set_addr_t SR_REG_TEST32 = 8'd60;

   // readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;
   localparam logic [3:0] RB_COMPAT  = 4'd6;

   // bump the major number when the register map changes
   localparam word_t COMPAT_NUM = {16'd10, 16'd0}; // major, minor

endpackage

`default_nettype wire

//--- design/ctrl_bus_pkg.sv
// control bus package with wishbone widths, slave decode codes and the misc register map
`default_nettype none

package ctrl_bus_pkg;

   // single master port, 16-bit data, byte addressed
   localparam int WB_DW = 16;
   localparam int WB_AW = 11;

   typedef logic [WB_DW-1:0] wb_data_t;
   typedef logic [WB_AW-1:0] wb_addr_t;

   // slave select comes from the top address bits
   localparam int DECODE_W = 4;
   localparam logic [DECODE_W-1:0] SLV_MISC     = 4'h0;
   localparam logic [DECODE_W-1:0] SLV_READBACK = 4'h7;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS = 4'h8; // msb only, upper half of the map

   // misc register offsets, low 7 address bits
   localparam logic [6:0] MISC_CGEN_CTRL = 7'd4;   // read/write
   localparam logic [6:0] MISC_CGEN_ST   = 7'd6;   // read only
   localparam logic [6:0] MISC_TEST      = 7'd8;   // scratch
   localparam wb_data_t   MISC_DEFAULT_RD = 16'hBEEF;
   localparam logic [1:0] CGEN_CTRL_RESET = 2'b11; // sync_b high, ref_sel high

endpackage

`default_nettype wire
